// ==== Makefile ====
# Verilator build for the serial boot memory testbench

VERILATOR ?= verilator
TOP       ?= tb_prog_ram
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation output is kept in a shell variable and searched for the pass message
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/prog_ram_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module prog_ram_checker (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic [31:0]  rd_data_i,
  input  logic         prog_mode_i,
  input  logic         sys_rst_ni,
  input  logic [127:0] test_name_i,
  input  logic         test_start_i,
  input  logic         test_end_i,
  input  logic [1:0]   exp_loads_i,
  input  logic         rd_check_i,
  input  logic [31:0]  rd_exp_i,
  output int           tests_o,
  output int           fails_o,
  output int           errors_o
);

  logic        mode_q;
  logic        rst_q;
  logic        rd_pend_q;
  logic [31:0] rd_exp_q;
  int          rises;
  int          pulses;
  int          low_len;
  int          test_errs;

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      mode_q    = 1'b0;
      rst_q     = 1'b1;
      rd_pend_q = 1'b0;
      rises     = 0;
      pulses    = 0;
      low_len   = 0;
      test_errs = 0;
      tests_o   = 0;
      fails_o   = 0;
      errors_o  = 0;
    end else begin
      // Read data is due one cycle after the request
      if (rd_pend_q && rd_data_i !== rd_exp_q) begin
        $display("mismatch %0s: expected %08h, actual %08h", test_name_i, rd_exp_q, rd_data_i);
        test_errs++;
      end
      rd_pend_q = rd_check_i;
      rd_exp_q  = rd_exp_i;

      ////////////////////
      // Mode and reset activity
      ////////////////////

      if (prog_mode_i && !mode_q) rises++;
      if (!sys_rst_ni && rst_q) pulses++;
      if (!sys_rst_ni) begin
        low_len++;
      end else if (low_len != 0) begin
        if (low_len != 1) begin
          $display("%0s: system reset stayed low for %0d cycles instead of one",
                   test_name_i, low_len);
          test_errs++;
        end
        low_len = 0;
      end
      mode_q = prog_mode_i;
      rst_q  = sys_rst_ni;

      if (test_start_i) begin
        rises     = 0;
        pulses    = 0;
        test_errs = 0;
      end

      if (test_end_i) begin
        if (rises != int'(exp_loads_i)) begin
          $display("%0s: program mode was entered %0d times, expected %0d times",
                   test_name_i, rises, exp_loads_i);
          test_errs++;
        end
        if (pulses != int'(exp_loads_i)) begin
          $display("%0s: saw %0d system reset pulses, expected %0d",
                   test_name_i, pulses, exp_loads_i);
          test_errs++;
        end
        tests_o++;
        errors_o += test_errs;
        if (test_errs == 0) begin
          $display("%0s passed", test_name_i);
        end else begin
          fails_o++;
          $display("%0s FAILED with %0d errors", test_name_i, test_errs);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_prog_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_prog_ram;

  typedef logic [prog_ram_pkg::ADDR_W-1:0] addr_t;
  typedef enum logic [2:0] {K_BUS, K_LOAD, K_BAD, K_BREAK, K_BUSY} kind_e;

  typedef struct packed {
    logic [127:0] name;
    kind_e        kind;
    addr_t        addr;
    logic [31:0]  data;
    logic [3:0]   strb;
    logic [3:0]   nwords;
    logic [1:0]   pulses;
  } test_t;

  localparam int N_TESTS = 9;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         rx;
  addr_t        bus_wr_addr;
  logic [31:0]  bus_wr_data;
  logic [3:0]   bus_wr_strb;
  logic         bus_rd_en;
  addr_t        bus_rd_addr;
  logic [31:0]  bus_rd_data;
  logic         prog_mode;
  logic         sys_rst_n;
  logic [127:0] test_name;
  logic         test_start;
  logic         test_end;
  logic [1:0]   exp_loads;
  logic         rd_check;
  logic [31:0]  rd_exp;
  int           tests_run;
  int           tests_failed;
  int           err_cnt;

  test_t       tests [N_TESTS];
  test_t       cur;
  logic [31:0] model_mem [prog_ram_pkg::RAM_DEPTH];
  logic [7:0]  tx_q [$];
  integer      seed = 32'heef3;
  int          cycle_cnt = 0;
  int          limit_cycles = 1000000;
  int          total_bytes;

  always #10 clk = ~clk;

  prog_ram_top u_prog_ram_top (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .rx_i          (rx),
    .bus_wr_addr_i (bus_wr_addr),
    .bus_wr_data_i (bus_wr_data),
    .bus_wr_strb_i (bus_wr_strb),
    .bus_rd_en_i   (bus_rd_en),
    .bus_rd_addr_i (bus_rd_addr),
    .bus_rd_data_o (bus_rd_data),
    .prog_mode_o   (prog_mode),
    .sys_rst_no    (sys_rst_n)
  );

  prog_ram_checker u_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .rd_data_i    (bus_rd_data),
    .prog_mode_i  (prog_mode),
    .sys_rst_ni   (sys_rst_n),
    .test_name_i  (test_name),
    .test_start_i (test_start),
    .test_end_i   (test_end),
    .exp_loads_i  (exp_loads),
    .rd_check_i   (rd_check),
    .rd_exp_i     (rd_exp),
    .tests_o      (tests_run),
    .fails_o      (tests_failed),
    .errors_o     (err_cnt)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= limit_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int frame_bytes(input kind_e k, input int n);
    if (k == K_BUS) return 0;
    if (k == K_BREAK) return 4 + prog_ram_pkg::SYNC_LEN + 4 + 4 * n;
    return prog_ram_pkg::SYNC_LEN + 4 + 4 * n;
  endfunction

  ////////////////////
  // Serial driver
  ////////////////////

  // 8N1 frame, start bit first, data LSB first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx <= frame[i];
      repeat (prog_ram_pkg::CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  task automatic send_queue();
    while (tx_q.size() > 0) begin
      send_byte(tx_q.pop_front());
    end
  endtask

  // Sync word, count MSB first, then the words; a bad sync ends in X
  task automatic build_frame(input logic sync_ok, input int n);
    logic [7:0]  b;
    logic [31:0] w;
    for (int i = prog_ram_pkg::SYNC_LEN - 1; i >= 0; i--) begin
      b = prog_ram_pkg::SYNC_WORD[i*8 +: 8];
      if (!sync_ok && i == 0) b = "X";
      tx_q.push_back(b);
    end
    w = n;
    for (int i = 3; i >= 0; i--) tx_q.push_back(w[i*8 +: 8]);
    for (int k = 0; k < n; k++) begin
      w = $random(seed);
      for (int i = 3; i >= 0; i--) tx_q.push_back(w[i*8 +: 8]);
      if (sync_ok) model_mem[k] = w;
    end
  endtask

  task automatic wait_reset_pulse();
    while (sys_rst_n) @(posedge clk);
  endtask

  ////////////////////
  // Bus driver
  ////////////////////

  task automatic bus_write(input addr_t a, input logic [31:0] d, input logic [3:0] s);
    bus_wr_addr <= a;
    bus_wr_data <= d;
    bus_wr_strb <= s;
    @(posedge clk);
    bus_wr_strb <= '0;
  endtask

  task automatic bus_write_in_load(input addr_t a, input logic [31:0] d, input logic [3:0] s);
    while (!prog_mode) @(posedge clk);
    bus_write(a, d, s);
  endtask

  task automatic model_write(input addr_t a, input logic [31:0] d, input logic [3:0] s);
    for (int i = 0; i < 4; i++) begin
      if (s[i]) model_mem[a][i*8 +: 8] = d[i*8 +: 8];
    end
  endtask

  task automatic read_check(input addr_t a);
    bus_rd_en   <= 1'b1;
    bus_rd_addr <= a;
    rd_check    <= 1'b1;
    rd_exp      <= model_mem[a];
    @(posedge clk);
    bus_rd_en <= 1'b0;
    rd_check  <= 1'b0;
    @(posedge clk);
  endtask

  initial begin
    rst_n <= 1'b0;
    rx <= 1'b1;
    bus_wr_addr <= '0;
    bus_wr_data <= '0;
    bus_wr_strb <= '0;
    bus_rd_en <= 1'b0;
    bus_rd_addr <= '0;
    test_name <= '0;
    test_start <= 1'b0;
    test_end <= 1'b0;
    exp_loads <= '0;
    rd_check <= 1'b0;
    rd_exp <= '0;
    for (int i = 0; i < prog_ram_pkg::RAM_DEPTH; i++) model_mem[i] = '0;

    tests[0] = '{"bus_full", K_BUS, 10'd500, 32'h11223344, 4'b1111, 4'd0, 2'd0};
    tests[1] = '{"bus_strb_0001", K_BUS, 10'd500, 32'ha5a5a5a5, 4'b0001, 4'd0, 2'd0};
    tests[2] = '{"bus_strb_0110", K_BUS, 10'd500, 32'h5a5a5a5a, 4'b0110, 4'd0, 2'd0};
    tests[3] = '{"bus_strb_1000", K_BUS, 10'd500, 32'hcafef00d, 4'b1000, 4'd0, 2'd0};
    tests[4] = '{"load_full", K_LOAD, 10'd0, 32'h0, 4'b0000, 4'd4, 2'd1};
    tests[5] = '{"bad_sync", K_BAD, 10'd0, 32'h0, 4'b0000, 4'd4, 2'd0};
    tests[6] = '{"seq_break", K_BREAK, 10'd0, 32'h0, 4'b0000, 4'd2, 2'd1};
    tests[7] = '{"reload", K_LOAD, 10'd0, 32'h0, 4'b0000, 4'd3, 2'd1};
    tests[8] = '{"bus_in_load", K_BUSY, 10'd500, 32'hdeadbeef, 4'b1111, 4'd2, 2'd1};

    total_bytes = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      total_bytes += frame_bytes(tests[t].kind, int'(tests[t].nwords));
    end
    limit_cycles = 2 * (total_bytes * 10 * prog_ram_pkg::CLKS_PER_BIT
                        + prog_ram_pkg::SEQ_BREAK_CYCLES + 200 * N_TESTS);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int t = 0; t < N_TESTS; t++) begin
      cur = tests[t];
      test_name  <= cur.name;
      exp_loads  <= cur.pulses;
      test_start <= 1'b1;
      @(posedge clk);
      test_start <= 1'b0;
      case (cur.kind)
        K_BUS: begin
          bus_write(cur.addr, cur.data, cur.strb);
          model_write(cur.addr, cur.data, cur.strb);
          read_check(cur.addr);
        end
        K_BAD: begin
          build_frame(1'b0, int'(cur.nwords));
          send_queue();
          // Let the partial sequence time out
          repeat (prog_ram_pkg::SEQ_BREAK_CYCLES + 100) @(posedge clk);
        end
        K_BREAK: begin
          for (int i = prog_ram_pkg::SYNC_LEN - 1; i >= prog_ram_pkg::SYNC_LEN - 4; i--) begin
            tx_q.push_back(prog_ram_pkg::SYNC_WORD[i*8 +: 8]);
          end
          send_queue();
          repeat (prog_ram_pkg::SEQ_BREAK_CYCLES + 100) @(posedge clk);
          build_frame(1'b1, int'(cur.nwords));
          fork
            send_queue();
            wait_reset_pulse();
          join
        end
        K_BUSY: begin
          build_frame(1'b1, int'(cur.nwords));
          fork
            send_queue();
            wait_reset_pulse();
            bus_write_in_load(cur.addr, cur.data, cur.strb);
          join
        end
        default: begin
          build_frame(1'b1, int'(cur.nwords));
          fork
            send_queue();
            wait_reset_pulse();
          join
        end
      endcase
      if (cur.kind != K_BUS) begin
        for (int a = 0; a < 4; a++) read_check(addr_t'(a));
      end
      if (cur.kind == K_BUSY) read_check(cur.addr);
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
    end

    repeat (2) @(posedge clk);
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (tests_run == N_TESTS && tests_failed == 0 && err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/prog_ram_pkg.sv
verilog/prog_word_if.sv
verilog/uart_rx.sv
verilog/prog_loader.sv
verilog/byte_ram.sv
verilog/prog_ram_top.sv
bench/prog_ram_checker.sv
bench/tb_prog_ram.sv

// ==== verilog/byte_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_ram (
  input  logic                              clk_i,
  prog_word_if.ram                          prog,
  input  logic [prog_ram_pkg::ADDR_W-1:0]   bus_wr_addr_i,
  input  logic [prog_ram_pkg::DATA_W-1:0]   bus_wr_data_i,
  input  logic [prog_ram_pkg::NB_COL-1:0]   bus_wr_strb_i,
  input  logic                              bus_rd_en_i,
  input  logic [prog_ram_pkg::ADDR_W-1:0]   bus_rd_addr_i,
  output logic [prog_ram_pkg::DATA_W-1:0]   bus_rd_data_o
);

  logic [prog_ram_pkg::DATA_W-1:0] mem [prog_ram_pkg::RAM_DEPTH];
  logic [prog_ram_pkg::DATA_W-1:0] rd_data_q;
  logic [prog_ram_pkg::NB_COL-1:0] lane_we;
  logic [prog_ram_pkg::ADDR_W-1:0] wr_addr;
  logic [prog_ram_pkg::DATA_W-1:0] wr_data;

  initial begin
    for (int i = 0; i < prog_ram_pkg::RAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Loader word wins over the bus
  assign wr_addr = prog.wr_valid ? prog.wr_addr : bus_wr_addr_i;
  assign wr_data = prog.wr_valid ? prog.wr_data : bus_wr_data_i;

  ////////////////////
  // Byte lanes
  ////////////////////

  // Bus strobes are masked for the whole program phase
  for (genvar g = 0; g < prog_ram_pkg::NB_COL; g++) begin : g_lane
    assign lane_we[g] = prog.wr_valid || (bus_wr_strb_i[g] && !prog.active);
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < prog_ram_pkg::NB_COL; i++) begin
      if (lane_we[i]) begin
        mem[wr_addr][i*prog_ram_pkg::COL_W +: prog_ram_pkg::COL_W] <=
          wr_data[i*prog_ram_pkg::COL_W +: prog_ram_pkg::COL_W];
      end
    end
  end

  // Registered read, old data on a same-address write
  always_ff @(posedge clk_i) begin
    if (bus_rd_en_i) begin
      rd_data_q <= mem[bus_rd_addr_i];
    end
  end

  assign bus_rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// ==== verilog/prog_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module prog_loader (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        byte_valid_i,
  input  logic [7:0]  byte_data_i,
  prog_word_if.loader prog,
  output logic        sys_rst_no
);

  typedef logic [$clog2(prog_ram_pkg::SEQ_BREAK_CYCLES)-1:0] idle_t;
  typedef logic [$clog2(prog_ram_pkg::SYNC_LEN)-1:0]         sync_cnt_t;

  prog_ram_pkg::loader_state_e state_q;
  prog_ram_pkg::loader_state_e state_d;

  logic [prog_ram_pkg::SYNC_LEN*8-1:0] sync_q;
  sync_cnt_t                           sync_cnt_q;
  idle_t                               idle_cnt_q;
  logic [1:0]                          byte_cnt_q;
  logic [31:0]                         word_cnt_q;
  logic [31:0]                         written_q;
  logic [prog_ram_pkg::DATA_W-1:0]     word_q;
  logic [prog_ram_pkg::ADDR_W-1:0]     load_addr_q;
  logic                                wr_valid_q;
  logic                                sys_rst_nq;
  logic                                last_sync;
  logic                                seq_break;
  logic [31:0]                         count_next;

  assign last_sync  = byte_valid_i &&
                      (sync_cnt_q == sync_cnt_t'(prog_ram_pkg::SYNC_LEN - 1));
  assign seq_break  = !byte_valid_i &&
                      (idle_cnt_q == idle_t'(prog_ram_pkg::SEQ_BREAK_CYCLES - 1));
  // Word count with the current byte shifted in, MSB first
  assign count_next = {word_cnt_q[23:0], byte_data_i};

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      prog_ram_pkg::SEQ_WAIT: begin
        if (byte_valid_i) begin
          state_d = prog_ram_pkg::SEQ_RECEIVE;
        end
      end
      prog_ram_pkg::SEQ_RECEIVE: begin
        if (last_sync) begin
          state_d = prog_ram_pkg::SEQ_CHECK;
        end else if (seq_break) begin
          state_d = prog_ram_pkg::SEQ_WAIT;
        end
      end
      prog_ram_pkg::SEQ_CHECK: begin
        state_d = (sync_q == prog_ram_pkg::SYNC_WORD) ? prog_ram_pkg::SEQ_LENGTH
                                                      : prog_ram_pkg::SEQ_WAIT;
      end
      prog_ram_pkg::SEQ_LENGTH: begin
        // Zero words skips the program phase
        if (byte_valid_i && &byte_cnt_q) begin
          state_d = (count_next == '0) ? prog_ram_pkg::SEQ_FINISH
                                       : prog_ram_pkg::SEQ_PROGRAM;
        end
      end
      prog_ram_pkg::SEQ_PROGRAM: begin
        if (written_q == word_cnt_q) begin
          state_d = prog_ram_pkg::SEQ_FINISH;
        end
      end
      default: state_d = prog_ram_pkg::SEQ_WAIT;
    endcase
  end

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= prog_ram_pkg::SEQ_WAIT;
      sync_cnt_q <= '0;
      idle_cnt_q <= '0;
      byte_cnt_q <= '0;
      written_q  <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      wr_valid_q <= 1'b0;
      case (state_q)
        prog_ram_pkg::SEQ_WAIT: begin
          idle_cnt_q <= '0;
          byte_cnt_q <= '0;
          sync_cnt_q <= byte_valid_i ? sync_cnt_t'(1) : '0;
        end
        prog_ram_pkg::SEQ_RECEIVE: begin
          if (byte_valid_i) begin
            idle_cnt_q <= '0;
            sync_cnt_q <= last_sync ? '0 : sync_cnt_q + 1'b1;
          end else if (seq_break) begin
            idle_cnt_q <= '0;
            sync_cnt_q <= '0;
          end else begin
            idle_cnt_q <= idle_cnt_q + 1'b1;
          end
        end
        prog_ram_pkg::SEQ_CHECK: begin
          byte_cnt_q <= '0;
          written_q  <= '0;
        end
        prog_ram_pkg::SEQ_LENGTH: begin
          if (byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
        end
        prog_ram_pkg::SEQ_PROGRAM: begin
          if (byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            // Fourth byte completes the word
            if (&byte_cnt_q) begin
              wr_valid_q <= 1'b1;
              written_q  <= written_q + 1'b1;
            end
          end
        end
        default: ;
      endcase
    end
  end

  // Byte shifters
  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      if (state_q == prog_ram_pkg::SEQ_WAIT || state_q == prog_ram_pkg::SEQ_RECEIVE) begin
        sync_q <= {sync_q[prog_ram_pkg::SYNC_LEN*8-9:0], byte_data_i};
      end
      if (state_q == prog_ram_pkg::SEQ_LENGTH) begin
        word_cnt_q <= count_next;
      end
      if (state_q == prog_ram_pkg::SEQ_PROGRAM) begin
        word_q <= {word_q[prog_ram_pkg::DATA_W-9:0], byte_data_i};
      end
    end
  end

  // One low cycle right after the finish state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sys_rst_nq <= 1'b1;
    end else begin
      sys_rst_nq <= (state_q != prog_ram_pkg::SEQ_FINISH);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni || !sys_rst_nq) begin
      load_addr_q <= '0;
    end else if (wr_valid_q) begin
      load_addr_q <= load_addr_q + 1'b1;
    end
  end

  assign prog.wr_valid = wr_valid_q;
  assign prog.wr_addr  = load_addr_q;
  assign prog.wr_data  = word_q;
  assign prog.active   = (state_q == prog_ram_pkg::SEQ_PROGRAM);
  assign sys_rst_no    = sys_rst_nq;

endmodule

`default_nettype wire

// ==== verilog/prog_ram_pkg.sv ====
`default_nettype none

package prog_ram_pkg;

  ////////////////////
  // RAM geometry
  ////////////////////

  localparam int NB_COL    = 4;
  localparam int COL_W     = 8;
  localparam int DATA_W    = NB_COL * COL_W;
  localparam int RAM_DEPTH = 1024;
  localparam int ADDR_W    = $clog2(RAM_DEPTH);

  // Serial bit time in clock cycles
  localparam int CLKS_PER_BIT = 16;

  ////////////////////
  // Loader sequence
  ////////////////////

  localparam int                    SYNC_LEN  = 9;
  localparam logic [SYNC_LEN*8-1:0] SYNC_WORD = "TEKNOFEST";

  // Idle cycles before a partial sync sequence is dropped
  localparam int SEQ_BREAK_CYCLES = 2000;

  typedef enum logic [2:0] {
    SEQ_WAIT    = 3'b000,
    SEQ_RECEIVE = 3'b001,
    SEQ_CHECK   = 3'b011,
    SEQ_LENGTH  = 3'b010,
    SEQ_PROGRAM = 3'b110,
    SEQ_FINISH  = 3'b100
  } loader_state_e;

endpackage

`default_nettype wire

// ==== verilog/prog_ram_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module prog_ram_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              rx_i,
  input  logic [prog_ram_pkg::ADDR_W-1:0]   bus_wr_addr_i,
  input  logic [prog_ram_pkg::DATA_W-1:0]   bus_wr_data_i,
  input  logic [prog_ram_pkg::NB_COL-1:0]   bus_wr_strb_i,
  input  logic                              bus_rd_en_i,
  input  logic [prog_ram_pkg::ADDR_W-1:0]   bus_rd_addr_i,
  output logic [prog_ram_pkg::DATA_W-1:0]   bus_rd_data_o,
  output logic                              prog_mode_o,
  output logic                              sys_rst_no
);

  // Receiver byte strobe
  logic       byte_valid;
  logic [7:0] byte_data;

  prog_word_if prog_if ();

  uart_rx u_uart_rx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_i         (rx_i),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data)
  );

  prog_loader u_prog_loader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .byte_valid_i (byte_valid),
    .byte_data_i  (byte_data),
    .prog         (prog_if),
    .sys_rst_no   (sys_rst_no)
  );

  byte_ram u_byte_ram (
    .clk_i         (clk_i),
    .prog          (prog_if),
    .bus_wr_addr_i (bus_wr_addr_i),
    .bus_wr_data_i (bus_wr_data_i),
    .bus_wr_strb_i (bus_wr_strb_i),
    .bus_rd_en_i   (bus_rd_en_i),
    .bus_rd_addr_i (bus_rd_addr_i),
    .bus_rd_data_o (bus_rd_data_o)
  );

  assign prog_mode_o = prog_if.active;

endmodule

`default_nettype wire

// ==== verilog/prog_word_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface prog_word_if;

  logic                              wr_valid;
  logic [prog_ram_pkg::ADDR_W-1:0]   wr_addr;
  logic [prog_ram_pkg::DATA_W-1:0]   wr_data;
  // High for the whole program phase
  logic                              active;

  modport loader (
    output wr_valid,
    output wr_addr,
    output wr_data,
    output active
  );

  modport ram (
    input wr_valid,
    input wr_addr,
    input wr_data,
    input active
  );

endinterface

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rx_i,
  output logic       byte_valid_o,
  output logic [7:0] byte_data_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  typedef logic [$clog2(prog_ram_pkg::CLKS_PER_BIT)-1:0] tmr_t;

  rx_state_e  state_q;
  logic [1:0] rx_sync_q;
  tmr_t       tmr_q;
  logic [2:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic       valid_q;
  logic       rx_s;
  logic       half_bit;
  logic       full_bit;

  assign rx_s     = rx_sync_q[1];
  assign half_bit = (tmr_q == tmr_t'(prog_ram_pkg::CLKS_PER_BIT / 2 - 1));
  assign full_bit = (tmr_q == tmr_t'(prog_ram_pkg::CLKS_PER_BIT - 1));

  // Two flops on the async line, idle level is high
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_sync_q <= 2'b11;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
    end
  end

  ////////////////////
  // Frame sequencer
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= RX_IDLE;
      tmr_q     <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          tmr_q <= '0;
          if (!rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Start bit must still be low at mid-bit
          if (half_bit) begin
            tmr_q     <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            tmr_q <= tmr_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (full_bit) begin
            tmr_q     <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            tmr_q <= tmr_q + 1'b1;
          end
        end
        RX_STOP: begin
          // Low stop bit is a framing error, byte dropped
          if (full_bit) begin
            tmr_q   <= '0;
            valid_q <= rx_s;
            state_q <= RX_IDLE;
          end else begin
            tmr_q <= tmr_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && full_bit) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign byte_valid_o = valid_q;
  assign byte_data_o  = shift_q;

endmodule

`default_nettype wire
